// ==== serial_sram_pkg.sv ====
/* shared constants for the serial SRAM port
   bit timing counters are cyc_w wide, so bit_cycles must stay below 2**cyc_w */
package serial_sram_pkg;

    localparam int addr_w = 19;                  // SRAM address bits
    localparam int byte_w = 8;

    // register numbers, first byte of a pair
    localparam logic [byte_w-1:0] reg_gpio     = 8'h01;
    localparam logic [byte_w-1:0] reg_addr_hi  = 8'h02;   // only low 3 bits used
    localparam logic [byte_w-1:0] reg_addr_mid = 8'h03;
    localparam logic [byte_w-1:0] reg_addr_lo  = 8'h04;
    localparam logic [byte_w-1:0] reg_len      = 8'h05;
    localparam logic [byte_w-1:0] reg_cmd      = 8'h06;

    // command codes
    localparam logic [byte_w-1:0] cmd_idle  = 8'h00;
    localparam logic [byte_w-1:0] cmd_read  = 8'h52;   // 'R'
    localparam logic [byte_w-1:0] cmd_sync  = 8'h53;   // 'S'
    localparam logic [byte_w-1:0] cmd_write = 8'h57;   // 'W'

    localparam logic [byte_w-1:0] sync_byte = 8'h53;   // payload of 'S'

    // default serial timing
    localparam int clk_freq           = 3_000_000;
    localparam int baud               = 1200;
    localparam int bit_cycles_default = clk_freq / baud;
    localparam int cyc_w              = 16;            // bit timer width

    localparam int fifo_depth = 4;                     // reply buffer entries

endpackage

// ==== uart_rx.sv ====
/* 8N1 receiver, samples at bit middles with no oversampling
   frames with a low stop bit are dropped silently */
module uart_rx #(
    parameter int bit_cycles = serial_sram_pkg::bit_cycles_default
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rx,
    output logic                               rx_valid,
    output logic [serial_sram_pkg::byte_w-1:0] rx_dat
);
    import serial_sram_pkg::*;

    logic             rx_s1;
    logic             rx_s2;
    logic             rx_prev;
    logic             busy;
    logic [3:0]       bit_idx;     // 0 start, 1..8 data, 9 stop
    logic [cyc_w-1:0] cyc;
    logic [cyc_w-1:0] cyc_end;
    logic             bit_mid;

    // half a bit to reach the middle of the start bit, then whole bits
    assign cyc_end = (bit_idx == 4'd0) ? cyc_w'(bit_cycles / 2 - 1) : cyc_w'(bit_cycles - 1);
    assign bit_mid = busy && (cyc == cyc_end);

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_prev  <= 1'b1;
            busy     <= 1'b0;
            bit_idx  <= 4'd0;
            cyc      <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_s1    <= rx;
            rx_s2    <= rx_s1;
            rx_prev  <= rx_s2;
            rx_valid <= 1'b0;
            if (!busy) begin
                cyc     <= '0;
                bit_idx <= 4'd0;
                if (rx_prev && !rx_s2) begin
                    busy <= 1'b1;              // falling edge of start bit
                end
            end else if (!bit_mid) begin
                cyc <= cyc + 1'b1;
            end else begin
                cyc     <= '0;
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0 && rx_s2) begin
                    busy <= 1'b0;              // glitch, not a real start
                end
                if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rx_s2;         // strobe only on a good stop bit
                end
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (bit_mid && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            rx_dat <= {rx_s2, rx_dat[byte_w-1:1]};
        end
    end

endmodule

// ==== cfg_frame.sv ====
/* groups received bytes into register/data pairs
   while a command runs every byte goes to the raw path and pairing restarts after */
module cfg_frame (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rx_valid,
    input  logic [serial_sram_pkg::byte_w-1:0] rx_dat,
    input  logic                               cmd_busy,
    output logic                               cfg_we,
    output logic [serial_sram_pkg::byte_w-1:0] cfg_addr,
    output logic [serial_sram_pkg::byte_w-1:0] cfg_dat,
    output logic                               raw_valid,
    output logic [serial_sram_pkg::byte_w-1:0] raw_dat
);
    import serial_sram_pkg::*;

    logic              pending;    // register number received, data byte next
    logic [byte_w-1:0] reg_num;

    always_ff @(posedge clk) begin
        if (reset || cmd_busy) begin
            pending <= 1'b0;
        end else if (rx_valid) begin
            pending <= !pending;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && !pending) begin
            reg_num <= rx_dat;
        end
    end

    assign cfg_we   = rx_valid && !cmd_busy && pending;
    assign cfg_addr = reg_num;
    assign cfg_dat  = rx_dat;

    assign raw_valid = rx_valid && cmd_busy;   // data for 'W', ignored otherwise
    assign raw_dat   = rx_dat;

    // pairing needs exactly one strobe per received byte
    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else $error("rx_valid high on two cycles in a row");

endmodule

// ==== sram_cmd_engine.sv ====
/* register file and command sequencer; assumes SRAM read data one cycle after address
   unknown command codes and len 0 leave the engine idle */
module sram_cmd_engine (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cfg_we,
    input  logic [serial_sram_pkg::byte_w-1:0] cfg_addr,
    input  logic [serial_sram_pkg::byte_w-1:0] cfg_dat,
    input  logic                               raw_valid,
    input  logic [serial_sram_pkg::byte_w-1:0] raw_dat,
    input  logic [serial_sram_pkg::byte_w-1:0] sram_din,
    input  logic                               push_ready,
    output logic                               cmd_busy,
    output logic [serial_sram_pkg::byte_w-1:0] gpio,
    output logic [serial_sram_pkg::addr_w-1:0] sram_addr,
    output logic [serial_sram_pkg::byte_w-1:0] sram_dout,
    output logic                               sram_we,
    output logic                               push_valid,
    output logic [serial_sram_pkg::byte_w-1:0] push_dat
);
    import serial_sram_pkg::*;

    logic [addr_w-1:0] addr;
    logic [byte_w-1:0] len;
    logic [byte_w-1:0] cmd;
    logic              capture;    // read data on sram_din this cycle
    logic              wr_pend;    // write strobe for the last raw byte
    logic              step;       // one byte of the command done
    logic              cmd_ok;

    assign cmd_busy  = (cmd != cmd_idle);
    assign sram_addr = addr;
    assign sram_we   = wr_pend;
    assign step      = wr_pend || (push_valid && push_ready);
    assign cmd_ok    = (cfg_dat == cmd_write) || (cfg_dat == cmd_read) || (cfg_dat == cmd_sync);

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio       <= '0;
            addr       <= '0;
            len        <= '0;
            cmd        <= cmd_idle;
            capture    <= 1'b0;
            wr_pend    <= 1'b0;
            push_valid <= 1'b0;
        end else begin
            wr_pend <= raw_valid && (cmd == cmd_write);
            capture <= 1'b0;

            if (cfg_we) begin
                case (cfg_addr)
                    reg_gpio:     gpio <= cfg_dat;
                    reg_addr_hi:  addr[addr_w-1:16] <= cfg_dat[addr_w-17:0];
                    reg_addr_mid: addr[15:8] <= cfg_dat;
                    reg_addr_lo:  addr[7:0] <= cfg_dat;
                    reg_len:      len <= cfg_dat;
                    reg_cmd: begin
                        if (cmd_ok && len != '0) begin
                            cmd <= cfg_dat;
                        end
                    end
                    default: ;                 // unused register numbers
                endcase
            end

            if (step) begin
                len <= len - 1'b1;
                if (len == 8'd1) begin
                    cmd <= cmd_idle;
                end
                if (cmd != cmd_sync) begin
                    addr <= addr + 1'b1;       // wraps at 19 bits
                end
            end

            // read: issue, capture, push  /  sync: push only
            if (push_valid) begin
                if (push_ready) begin
                    push_valid <= 1'b0;
                end
            end else if (capture) begin
                push_valid <= 1'b1;
            end else if (cmd == cmd_read) begin
                capture <= 1'b1;
            end else if (cmd == cmd_sync) begin
                push_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!push_valid) begin
            if (capture) begin
                push_dat <= sram_din;
            end else if (cmd == cmd_sync) begin
                push_dat <= sync_byte;
            end
        end
        if (raw_valid) begin
            sram_dout <= raw_dat;
        end
    end

    a_push_hold: assert property (@(posedge clk) disable iff (reset)
        push_valid && !push_ready |=> push_valid && $stable(push_dat))
        else $error("push byte changed before transfer");

    a_we_in_write: assert property (@(posedge clk) disable iff (reset)
        sram_we |-> cmd == cmd_write)
        else $error("sram_we outside write command");

endmodule

// ==== tx_byte_fifo.sv ====
/* circular byte FIFO with valid/ready on both sides, depth of 2 or more
   a pushed byte shows at the output on the next cycle */
module tx_byte_fifo #(
    parameter int depth = serial_sram_pkg::fifo_depth
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               push_valid,
    input  logic [serial_sram_pkg::byte_w-1:0] push_dat,
    input  logic                               pop_ready,
    output logic                               push_ready,
    output logic                               pop_valid,
    output logic [serial_sram_pkg::byte_w-1:0] pop_dat
);
    import serial_sram_pkg::*;

    logic [byte_w-1:0]            mem [depth];
    logic [$clog2(depth)-1:0]     wr_ptr;
    logic [$clog2(depth)-1:0]     rd_ptr;
    logic [$clog2(depth+1)-1:0]   count;
    logic                         do_push;
    logic                         do_pop;

    assign push_ready = (count != ($clog2(depth+1))'(depth));
    assign pop_valid  = (count != '0);
    assign pop_dat    = mem[rd_ptr];
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                     // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_dat;
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (reset)
        count <= ($clog2(depth+1))'(depth))
        else $error("fifo count above depth");

endmodule

// ==== uart_tx.sv ====
/* 8N1 transmitter, one byte per handshake, ready only between frames */
module uart_tx #(
    parameter int bit_cycles = serial_sram_pkg::bit_cycles_default
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               pop_valid,
    input  logic [serial_sram_pkg::byte_w-1:0] pop_dat,
    output logic                               pop_ready,
    output logic                               tx
);
    import serial_sram_pkg::*;

    logic                busy;
    logic [byte_w+1:0]   frame;     // stop, data, start; lsb goes out first
    logic [3:0]          bit_idx;
    logic [cyc_w-1:0]    cyc;
    logic                bit_end;

    assign pop_ready = !busy;
    assign bit_end   = (cyc == cyc_w'(bit_cycles - 1));
    assign tx        = busy ? frame[0] : 1'b1;   // line idles high

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            bit_idx <= 4'd0;
            cyc     <= '0;
        end else if (!busy) begin
            cyc     <= '0;
            bit_idx <= 4'd0;
            if (pop_valid) begin
                busy <= 1'b1;
            end
        end else if (!bit_end) begin
            cyc <= cyc + 1'b1;
        end else begin
            cyc     <= '0;
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;                  // stop bit done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && pop_valid) begin
            frame <= {1'b1, pop_dat, 1'b0};
        end else if (busy && bit_end) begin
            frame <= {1'b1, frame[byte_w+1:1]};
        end
    end

endmodule

// ==== serial_sram_top.sv ====
/* serial-controlled SRAM port; the SRAM sits outside with a one-cycle synchronous read
   bit_cycles is clocks per serial bit on both rx and tx */
module serial_sram_top #(
    parameter int bit_cycles = serial_sram_pkg::bit_cycles_default
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rx,
    input  logic [serial_sram_pkg::byte_w-1:0] sram_din,
    output logic                               tx,
    output logic [serial_sram_pkg::byte_w-1:0] gpio,
    output logic [serial_sram_pkg::addr_w-1:0] sram_addr,
    output logic [serial_sram_pkg::byte_w-1:0] sram_dout,
    output logic                               sram_we
);
    import serial_sram_pkg::*;

    logic              rx_valid;
    logic [byte_w-1:0] rx_dat;
    logic              cfg_we;
    logic [byte_w-1:0] cfg_addr;
    logic [byte_w-1:0] cfg_dat;
    logic              raw_valid;
    logic [byte_w-1:0] raw_dat;
    logic              cmd_busy;
    logic              push_valid;
    logic              push_ready;
    logic [byte_w-1:0] push_dat;
    logic              pop_valid;
    logic              pop_ready;
    logic [byte_w-1:0] pop_dat;

    uart_rx #(.bit_cycles(bit_cycles)) u_uart_rx (
        .clk(clk), .reset(reset), .rx(rx), .rx_valid(rx_valid), .rx_dat(rx_dat)
    );

    cfg_frame u_cfg_frame (
        .clk(clk), .reset(reset), .rx_valid(rx_valid), .rx_dat(rx_dat), .cmd_busy(cmd_busy),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_dat(cfg_dat),
        .raw_valid(raw_valid), .raw_dat(raw_dat)
    );

    sram_cmd_engine u_sram_cmd_engine (
        .clk(clk), .reset(reset), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_dat(cfg_dat),
        .raw_valid(raw_valid), .raw_dat(raw_dat), .sram_din(sram_din),
        .push_ready(push_ready), .cmd_busy(cmd_busy), .gpio(gpio), .sram_addr(sram_addr),
        .sram_dout(sram_dout), .sram_we(sram_we), .push_valid(push_valid), .push_dat(push_dat)
    );

    tx_byte_fifo #(.depth(fifo_depth)) u_tx_byte_fifo (
        .clk(clk), .reset(reset), .push_valid(push_valid), .push_dat(push_dat),
        .pop_ready(pop_ready), .push_ready(push_ready), .pop_valid(pop_valid), .pop_dat(pop_dat)
    );

    uart_tx #(.bit_cycles(bit_cycles)) u_uart_tx (
        .clk(clk), .reset(reset), .pop_valid(pop_valid), .pop_dat(pop_dat),
        .pop_ready(pop_ready), .tx(tx)
    );

endmodule

// ==== tb_serial_sram.sv ====
/* testbench for serial_sram_top at 16 clocks per bit, SRAM modeled with a one-cycle read
   stops at the first mismatch or timeout */
module tb_serial_sram;
    timeunit 1ns;
    timeprecision 100ps;
    import serial_sram_pkg::*;

    typedef logic [byte_w-1:0] byte_q_t [$];

    localparam int bit_t = 16;                 // clocks per serial bit

    logic              clk;
    logic              reset;
    logic              rx;
    logic [byte_w-1:0] sram_din;
    logic              tx;
    logic [byte_w-1:0] gpio;
    logic [addr_w-1:0] sram_addr;
    logic [byte_w-1:0] sram_dout;
    logic              sram_we;

    logic [byte_w-1:0]        sram_mem [1 << addr_w];
    logic [byte_w-1:0]        shadow_mem [logic [addr_w-1:0]];
    logic [addr_w-1:0]        shadow_addr;
    logic [byte_w-1:0]        exp_gpio;
    logic [addr_w+byte_w-1:0] wr_q [$];        // expected {address, data} of SRAM writes
    byte_q_t                  rx_q;            // bytes decoded from tx
    byte_q_t                  exp_q;
    int                       seed = 32'hca47;

    serial_sram_top #(.bit_cycles(bit_t)) u_serial_sram_top (
        .clk(clk), .reset(reset), .rx(rx), .sram_din(sram_din), .tx(tx), .gpio(gpio),
        .sram_addr(sram_addr), .sram_dout(sram_dout), .sram_we(sram_we)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAILED at %0d ns: %s is %0h, expected %0h",
                                $time, name, got, want));
        end
    endtask

    // reply of a command as the register rules define it
    function automatic byte_q_t reply_bytes(input logic [byte_w-1:0] cmd,
                                            input logic [addr_w-1:0] start, input int len);
        byte_q_t           q;
        logic [addr_w-1:0] a;
        int                i;
        a = start;
        for (i = 0; i < len; i++) begin
            if (cmd == cmd_read) begin
                q.push_back(shadow_mem[a]);
            end else if (cmd == cmd_sync) begin
                q.push_back(sync_byte);
            end
            a = a + addr_w'(1);                // wraps like the engine
        end
        return q;
    endfunction

    task automatic send_byte(input logic [byte_w-1:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        repeat (10) begin
            @(posedge clk);
            #1;
            rx = frame[0];
            frame = frame >> 1;
            repeat (bit_t - 1) @(posedge clk);
        end
    endtask

    task automatic send_pair(input logic [byte_w-1:0] num, input logic [byte_w-1:0] val);
        send_byte(num);
        send_byte(val);
    endtask

    task automatic settle_outputs();
        int n;
        n = 0;
        while ((gpio !== exp_gpio || sram_addr !== shadow_addr) && n < 4 * bit_t) begin
            @(negedge clk);
            n++;
        end
        check_equal("gpio", 32'(gpio), 32'(exp_gpio));
        check_equal("sram_addr", 32'(sram_addr), 32'(shadow_addr));
    endtask

    task automatic wait_drained(input string what, input int limit);
        int n;
        n = 0;
        while (wr_q.size() != 0 || exp_q.size() != 0) begin
            if (n == limit) begin
                abort_run({"timed out waiting for ", what});
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic set_gpio(input logic [byte_w-1:0] val);
        exp_gpio = val;
        send_pair(reg_gpio, val);
        settle_outputs();
    endtask

    task automatic set_address(input logic [addr_w-1:0] a, input logic [4:0] upper);
        shadow_addr = a;
        send_pair(reg_addr_hi, {upper, a[18:16]});   // upper bits are don't care
        send_pair(reg_addr_mid, a[15:8]);
        send_pair(reg_addr_lo, a[7:0]);
        settle_outputs();
    endtask

    task automatic run_write(input int n);
        logic [byte_w-1:0] d;
        int                rnd;
        send_pair(reg_len, byte_w'(n));
        send_pair(reg_cmd, cmd_write);
        repeat (n) begin
            rnd = $random(seed);
            d = rnd[7:0];
            wr_q.push_back({shadow_addr, d});
            shadow_mem[shadow_addr] = d;
            shadow_addr = shadow_addr + addr_w'(1);
            send_byte(d);
        end
        wait_drained("SRAM write strobes", 4 * bit_t);
        settle_outputs();
    endtask

    task automatic run_reply(input logic [byte_w-1:0] cmd, input int n, input int junk);
        byte_q_t q;
        int      rnd;
        q = reply_bytes(cmd, shadow_addr, n);
        foreach (q[k]) exp_q.push_back(q[k]);
        send_pair(reg_len, byte_w'(n));
        send_pair(reg_cmd, cmd);
        repeat (junk) begin
            rnd = $random(seed);
            send_byte(rnd[7:0]);               // dropped while busy
        end
        wait_drained("reply bytes on tx", (n + 2) * 20 * bit_t);
        if (cmd == cmd_read) begin
            shadow_addr = shadow_addr + addr_w'(n);
        end
        settle_outputs();
    endtask

    // SRAM with writes checked against the expected list
    initial begin : sram_model
        logic [addr_w+byte_w-1:0] wr;
        logic [addr_w-1:0]        rd_addr;
        sram_din = '0;
        forever begin
            @(negedge clk);
            if (sram_we === 1'b1) begin
                if (wr_q.size() == 0) begin
                    abort_run("sram_we pulsed while no SRAM write was expected");
                end else begin
                    wr = wr_q.pop_front();
                    check_equal("sram_addr", 32'(sram_addr), 32'(wr[addr_w+byte_w-1:byte_w]));
                    check_equal("sram_dout", 32'(sram_dout), 32'(wr[byte_w-1:0]));
                end
                sram_mem[sram_addr] = sram_dout;
            end
            rd_addr = sram_addr;
            @(posedge clk);
            #1;
            sram_din = sram_mem[rd_addr];      // one cycle after the address
        end
    end

    initial begin : tx_monitor
        logic [byte_w-1:0] b;
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                repeat (bit_t / 2 - 1) @(negedge clk);   // middle of start bit
                repeat (8) begin
                    repeat (bit_t) @(negedge clk);
                    b = {tx, b[byte_w-1:1]};
                end
                repeat (bit_t) @(negedge clk);
                if (tx !== 1'b1) begin
                    abort_run("stop bit on tx was not high");
                end
                rx_q.push_back(b);
            end
        end
    end

    initial begin : compare_replies
        logic [byte_w-1:0] got;
        logic [byte_w-1:0] want;
        forever begin
            @(negedge clk);
            if (rx_q.size() != 0) begin
                got = rx_q.pop_front();
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("unexpected extra byte %0h on tx", got));
                end else begin
                    want = exp_q.pop_front();
                    check_equal("tx byte", 32'(got), 32'(want));
                end
            end
        end
    end

    initial begin : test_sequence
        rx = 1'b1;
        reset = 1'b1;
        shadow_addr = '0;
        exp_gpio = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (2 * bit_t) begin
            @(negedge clk);
            check_equal("tx", 32'(tx), 32'd1);
            check_equal("sram_we", 32'(sram_we), 32'd0);
            check_equal("gpio", 32'(gpio), 32'd0);
        end
        set_gpio(8'ha5);
        set_address(19'h2_3456, 5'b10101);
        run_write(5);
        set_address(19'h7_fffa, 5'b11111);
        run_write(12);                         // crosses the address wrap
        set_address(19'h2_3456, 5'b00000);
        run_reply(cmd_read, 5, 0);
        set_address(19'h7_fffa, 5'b01010);
        run_reply(cmd_read, 12, 3);            // FIFO full, engine stalls
        run_reply(cmd_sync, 5, 0);
        run_reply(cmd_sync, 0, 0);
        set_gpio(8'h3c);                       // pairs decode again
        repeat (20 * bit_t) begin
            @(negedge clk);
            check_equal("tx", 32'(tx), 32'd1);
        end
        if (rx_q.size() != 0 || exp_q.size() != 0) begin
            abort_run("number of reply bytes differs at the end of the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== serial_sram.f ====
serial_sram_pkg.sv
uart_rx.sv
cfg_frame.sv
sram_cmd_engine.sv
tx_byte_fifo.sv
uart_tx.sv
serial_sram_top.sv
tb_serial_sram.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the serial SRAM testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_serial_sram -f serial_sram.f -o sim_serial_sram
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_serial_sram 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
